//--- Bender.yml
package:
  name: psx_host_ctrl

sources:
  - source/psx_host_pkg.sv
  - source/dl_kind_decode.sv
  - source/ram_load_fsm.sv
  - source/cheat_code_asm.sv
  - source/osd_pause_ctrl.sv
  - source/psx_host_ctrl.sv
  - target: test
    files:
      - tests/psx_host_ctrl_assert.sv
      - tests/tb_psx_host_ctrl.sv

//--- psx_host_ctrl.f
source/psx_host_pkg.sv
source/dl_kind_decode.sv
source/ram_load_fsm.sv
source/cheat_code_asm.sv
source/osd_pause_ctrl.sv
source/psx_host_ctrl.sv
tests/psx_host_ctrl_assert.sv
tests/tb_psx_host_ctrl.sv

//--- source/cheat_code_asm.sv
// Cheat code assembler
`timescale 1ns/100ps
`default_nettype none

module cheat_code_asm import psx_host_pkg::*; (
	input  wire logic      clk_1x,
	input  wire logic      arst_n,
	input  wire dl_kind_t  dl_kind,
	input  wire logic      ioctl_wr,
	input  wire ram_addr_t ioctl_addr,
	input  wire half_t     ioctl_dout,
	output cheat_code_t    cheat_code,
	output logic           cheat_valid
);

	logic code_wr;

	assign code_wr = (dl_kind == DL_CODE) && ioctl_wr;

	// ==============================
	// Slice steering
	// ==============================
	// Each 32-bit field arrives low half first
	always_ff @(posedge clk_1x) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= ioctl_dout;
				4'd2:  cheat_code[127:112] <= ioctl_dout;
				4'd4:  cheat_code[79:64]   <= ioctl_dout;
				4'd6:  cheat_code[95:80]   <= ioctl_dout;
				4'd8:  cheat_code[47:32]   <= ioctl_dout;
				4'd10: cheat_code[63:48]   <= ioctl_dout;
				4'd12: cheat_code[15:0]    <= ioctl_dout;
				4'd14: cheat_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Replace high half closes the code
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_wr && (ioctl_addr[3:0] == 4'd14);
	end

endmodule

`default_nettype wire

//--- source/dl_kind_decode.sv
// Download kind decoder
`timescale 1ns/100ps
`default_nettype none

module dl_kind_decode import psx_host_pkg::*; (
	input  wire logic      clk_1x,
	input  wire logic      arst_n,
	input  wire logic      ioctl_download,
	input  wire dl_index_t ioctl_index,
	input  wire logic      reset_req,
	output dl_kind_t       dl_kind,
	output logic           load_exe,
	output logic           cheat_clear,
	output logic           sys_reset
);

	dl_kind_t kind_d;
	dl_kind_t kind_prev;

	// Index lookup, only while the host streams
	always_comb begin
		kind_d = DL_NONE;
		if (ioctl_download) begin
			case (ioctl_index)
				IDX_BIOS:   kind_d = DL_BIOS;
				IDX_EXE:    kind_d = DL_EXE;
				// Libcrypt key image, recognised only
				IDX_SBI:    kind_d = DL_SBI;
				IDX_CDINFO: kind_d = DL_CDINFO;
				IDX_CODE:   kind_d = DL_CODE;
				default:    kind_d = DL_NONE;
			endcase
		end
	end

	// ==============================
	// Kind register and edge pulses
	// ==============================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_kind     <= DL_NONE;
			kind_prev   <= DL_NONE;
			load_exe    <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			dl_kind   <= kind_d;
			kind_prev <= dl_kind;
			// Executable fully in memory, start it
			load_exe  <= (kind_prev == DL_EXE) && (dl_kind != DL_EXE);
			// New code list replaces whatever was active
			cheat_clear <= (dl_kind == DL_CODE) && (kind_prev != DL_CODE);
		end
	end

	// Hold the core in reset while an image is written over it
	assign sys_reset = reset_req || (dl_kind == DL_BIOS) || (dl_kind == DL_EXE);

endmodule

`default_nettype wire

//--- source/osd_pause_ctrl.sv
// Menu pause with frame advance
`timescale 1ns/100ps
`default_nettype none

module osd_pause_ctrl import psx_host_pkg::*; (
	input  wire logic clk_1x,
	input  wire logic arst_n,
	input  wire logic osd_open,
	input  wire logic pause_on_osd,
	input  wire logic advance_req,
	output logic      paused
);

	logic     advance_q;
	logic     advance_rise;
	holdoff_t holdoff;

	assign advance_rise = advance_req && !advance_q;

	// ==============================
	// Hold-off counter
	// ==============================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			advance_q <= 1'b0;
			holdoff   <= '0;
		end else begin
			advance_q <= advance_req;
			if (advance_rise)
				holdoff <= HOLDOFF_CYCLES;
			else if (holdoff != '0)
				holdoff <= holdoff - 1'b1;
		end
	end

	// Pause only once the advance window has run out
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n)
			paused <= 1'b0;
		else
			paused <= pause_on_osd && osd_open && (holdoff == '0);
	end

endmodule

`default_nettype wire

//--- source/psx_host_ctrl.sv
// Host loader and pause front end
`timescale 1ns/100ps
`default_nettype none

module psx_host_ctrl import psx_host_pkg::*; (
	input  wire logic      clk_1x,
	input  wire logic      arst_n,

	// Host download port
	input  wire logic      ioctl_download,
	input  wire dl_index_t ioctl_index,
	input  wire logic      ioctl_wr,
	input  wire ram_addr_t ioctl_addr,
	input  wire half_t     ioctl_dout,
	output logic           ioctl_wait,

	// Memory write port
	output logic           ram_wr,
	output logic           trackinfo_wr,
	output ram_addr_t      mem_addr,
	output word_t          mem_data,
	input  wire logic      ram_ack,

	// Cheats
	output cheat_code_t    cheat_code,
	output logic           cheat_valid,
	output logic           cheat_clear,

	// System control
	input  wire logic      reset_req,
	output logic           load_exe,
	output logic           sys_reset,

	// Menu pause
	input  wire logic      osd_open,
	input  wire logic      pause_on_osd,
	input  wire logic      advance_req,
	output logic           paused
);

	dl_kind_t dl_kind;

	// ==============================
	// Download side
	// ==============================
	dl_kind_decode u_dl_kind_decode (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.reset_req      (reset_req),
		.dl_kind        (dl_kind),
		.load_exe       (load_exe),
		.cheat_clear    (cheat_clear),
		.sys_reset      (sys_reset)
	);

	ram_load_fsm u_ram_load_fsm (
		.clk_1x       (clk_1x),
		.arst_n       (arst_n),
		.dl_kind      (dl_kind),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.ram_ack      (ram_ack),
		.ioctl_wait   (ioctl_wait),
		.ram_wr       (ram_wr),
		.trackinfo_wr (trackinfo_wr),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data)
	);

	cheat_code_asm u_cheat_code_asm (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.dl_kind     (dl_kind),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	// ==============================
	// Pause
	// ==============================
	osd_pause_ctrl u_osd_pause_ctrl (
		.clk_1x       (clk_1x),
		.arst_n       (arst_n),
		.osd_open     (osd_open),
		.pause_on_osd (pause_on_osd),
		.advance_req  (advance_req),
		.paused       (paused)
	);

endmodule

`default_nettype wire

//--- source/psx_host_pkg.sv
// Host loader definitions
`default_nettype none

package psx_host_pkg;

	// ==============================
	// Widths and data types
	// ==============================
	localparam int HALF_W  = 16;
	localparam int WORD_W  = 32;
	localparam int ADDR_W  = 27;
	localparam int TRACK_W = 9;
	localparam int CODE_W  = 128;
	localparam int INDEX_W = 8;

	typedef logic [HALF_W-1:0]  half_t;
	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [ADDR_W-1:0]  ram_addr_t;
	// Word index into track info, mem_addr[10:2]
	typedef logic [TRACK_W-1:0] track_addr_t;
	// {flags, address, compare, replace}, 32 bits each
	typedef logic [CODE_W-1:0]  cheat_code_t;
	typedef logic [INDEX_W-1:0] dl_index_t;

	// ==============================
	// Download kinds
	// ==============================
	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_SBI,
		DL_CDINFO,
		DL_CODE
	} dl_kind_t;

	localparam dl_index_t IDX_BIOS   = 8'd0;
	localparam dl_index_t IDX_EXE    = 8'd1;
	localparam dl_index_t IDX_SBI    = 8'd250;
	localparam dl_index_t IDX_CDINFO = 8'd251;
	localparam dl_index_t IDX_CODE   = 8'd255;

	// Memory offsets of the two image kinds
	localparam ram_addr_t BIOS_BASE = 27'd2097152;
	localparam ram_addr_t EXE_BASE  = 27'd4194304;

	// ==============================
	// Loader and pause
	// ==============================
	typedef enum logic [1:0] {
		LD_LOW,
		LD_HIGH,
		LD_ACK
	} ld_state_t;

	localparam int HOLDOFF_W = 10;
	typedef logic [HOLDOFF_W-1:0] holdoff_t;
	localparam holdoff_t HOLDOFF_CYCLES = 10'd1023;

endpackage

`default_nettype wire

//--- source/ram_load_fsm.sv
// Half-word pairing loader
`timescale 1ns/100ps
`default_nettype none

module ram_load_fsm import psx_host_pkg::*; (
	input  wire logic      clk_1x,
	input  wire logic      arst_n,
	input  wire dl_kind_t  dl_kind,
	input  wire logic      ioctl_wr,
	input  wire ram_addr_t ioctl_addr,
	input  wire half_t     ioctl_dout,
	input  wire logic      ram_ack,
	output logic           ioctl_wait,
	output logic           ram_wr,
	output logic           trackinfo_wr,
	output ram_addr_t      mem_addr,
	output word_t          mem_data
);

	ld_state_t state;
	ld_state_t state_nxt;
	logic      served;
	logic      to_mem;
	logic      take_low;
	logic      take_high;
	ram_addr_t base;

	// Kinds that end up as 32-bit writes
	assign served = (dl_kind == DL_BIOS) || (dl_kind == DL_EXE) || (dl_kind == DL_CDINFO);
	// Track info bypasses memory and never waits
	assign to_mem = (dl_kind == DL_BIOS) || (dl_kind == DL_EXE);

	assign take_low  = served && ioctl_wr && !ioctl_addr[1] && (state != LD_ACK);
	assign take_high = served && ioctl_wr && ioctl_addr[1] && (state == LD_HIGH);

	always_comb begin
		case (dl_kind)
			DL_BIOS: base = BIOS_BASE;
			DL_EXE:  base = EXE_BASE;
			default: base = '0;
		endcase
	end

	// ==============================
	// Next state
	// ==============================
	always_comb begin
		state_nxt = state;
		case (state)
			LD_LOW: begin
				if (take_low)
					state_nxt = LD_HIGH;
			end
			LD_HIGH: begin
				if (take_high)
					state_nxt = to_mem ? LD_ACK : LD_LOW;
			end
			LD_ACK: begin
				if (ram_ack)
					state_nxt = LD_LOW;
			end
			default: state_nxt = LD_LOW;
		endcase
		// Download gone or switched to another kind
		if (!served)
			state_nxt = LD_LOW;
	end

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			state        <= LD_LOW;
			ram_wr       <= 1'b0;
			trackinfo_wr <= 1'b0;
			ioctl_wait   <= 1'b0;
		end else begin
			state        <= state_nxt;
			ram_wr       <= take_high && to_mem;
			trackinfo_wr <= take_high && !to_mem;
			// Host held for the whole memory round trip
			ioctl_wait   <= (state_nxt == LD_ACK);
		end
	end

	// Write payload, low half plus offset address first
	always_ff @(posedge clk_1x) begin
		if (take_low) begin
			mem_data[15:0] <= ioctl_dout;
			mem_addr       <= ioctl_addr + base;
		end
		if (take_high)
			mem_data[31:16] <= ioctl_dout;
	end

endmodule

`default_nettype wire

//--- tests/psx_host_ctrl_assert.sv
// Host loader port assertions
`timescale 1ns/100ps
`default_nettype none

module psx_host_ctrl_assert (
	input wire logic clk_1x,
	input wire logic arst_n,
	input wire logic ioctl_download,
	input wire logic ioctl_wait,
	input wire logic ram_wr,
	input wire logic trackinfo_wr,
	input wire logic cheat_valid,
	input wire logic cheat_clear
);

	// Failure tally, read back by the testbench
	int unsigned assert_fails = 0;

	// ==============================
	// Host and memory strobes
	// ==============================
	// Wait can outlast the download by the decode delay
	a_wait_in_download: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ioctl_wait |-> (ioctl_download || $past(ioctl_download, 2)))
	else begin
		assert_fails++;
		$error("ioctl_wait high outside a download");
	end

	a_one_write_kind: assert property (@(posedge clk_1x) disable iff (!arst_n)
		!(ram_wr && trackinfo_wr))
	else begin
		assert_fails++;
		$error("ram_wr and trackinfo_wr high together");
	end

	a_wait_with_write: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ram_wr |-> ioctl_wait)
	else begin
		assert_fails++;
		$error("ram_wr without ioctl_wait");
	end

	a_cheat_pulses: assert property (@(posedge clk_1x) disable iff (!arst_n)
		!(cheat_valid && cheat_clear))
	else begin
		assert_fails++;
		$error("cheat_valid and cheat_clear in the same cycle");
	end

endmodule

bind psx_host_ctrl psx_host_ctrl_assert u_psx_host_ctrl_assert (.*);

`default_nettype wire

//--- tests/tb_psx_host_ctrl.sv
// Host loader testbench
`timescale 1ns/100ps
`default_nettype none

module tb_psx_host_ctrl import psx_host_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int N_BIOS     = 40;
	localparam int N_EXE      = 40;
	localparam int N_CDINFO   = 30;
	localparam int N_CODES    = 6;
	// Half-word strobes of the whole run with nine per code
	localparam int N_TRANSFERS     = 2 * (N_BIOS + N_EXE + N_CDINFO) + 9 * N_CODES;
	localparam int WATCHDOG_CYCLES = N_TRANSFERS * 20 + 4000;

	logic        clk_1x, arst_n;
	logic        ioctl_download, ioctl_wr, ioctl_wait;
	dl_index_t   ioctl_index;
	ram_addr_t   ioctl_addr, mem_addr;
	half_t       ioctl_dout;
	logic        ram_wr, trackinfo_wr, ram_ack;
	word_t       mem_data;
	cheat_code_t cheat_code;
	logic        cheat_valid, cheat_clear;
	logic        reset_req, load_exe, sys_reset;
	logic        osd_open, pause_on_osd, advance_req, paused;

	logic [31:0] rng_state = 32'h5497;
	int          errors = 0;
	int          checks = 0;
	int          load_exe_seen = 0;
	int          clear_seen = 0;
	int          valid_seen = 0;
	int unsigned asserts;
	// Expected writes in issue order
	dl_kind_t    exp_kind_q[$];
	ram_addr_t   exp_addr_q[$];
	word_t       exp_data_q[$];

	psx_host_ctrl u_psx_host_ctrl (.*);

	initial begin
		clk_1x = 1'b0;
		forever #(CLK_PERIOD / 2) clk_1x = ~clk_1x;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run never finished", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	// ==============================
	// Random source and compares
	// ==============================
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_code(input cheat_code_t got, input cheat_code_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t cheat_code: got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_write(input logic track, input dl_kind_t kind,
			input ram_addr_t addr_got, input ram_addr_t addr_exp,
			input word_t data_got, input word_t data_exp);
		checks++;
		if (track !== (kind == DL_CDINFO)) begin
			errors++;
			$display("FAILED %0t trackinfo_wr: got %b expected %b", $time, track,
				kind == DL_CDINFO);
		end
		if (addr_got !== addr_exp) begin
			errors++;
			$display("FAILED %0t mem_addr: got %h expected %h", $time, addr_got, addr_exp);
		end
		if (data_got !== data_exp) begin
			errors++;
			$display("FAILED %0t mem_data: got %h expected %h", $time, data_got, data_exp);
		end
	endtask

	// Write and pulse monitor
	always @(negedge clk_1x) begin
		if (arst_n && (ram_wr || trackinfo_wr)) begin
			if (exp_kind_q.size() == 0) begin
				errors++;
				$display("Write strobe at %0t with no transfer pending", $time);
			end else begin
				check_write(trackinfo_wr, exp_kind_q.pop_front(), mem_addr,
					exp_addr_q.pop_front(), mem_data, exp_data_q.pop_front());
			end
		end
		load_exe_seen += int'(load_exe);
		clear_seen    += int'(cheat_clear);
		valid_seen    += int'(cheat_valid);
	end

	// ==============================
	// Host and memory stimulus
	// ==============================
	task automatic set_download(input logic active, input dl_index_t idx);
		@(negedge clk_1x);
		ioctl_download = active;
		ioctl_index    = idx;
		repeat (2) @(negedge clk_1x);
	endtask

	// Low and high half at a random word address and then the memory ack
	task automatic write_pair(input dl_kind_t kind);
		logic [31:0] r;
		ram_addr_t   addr;
		ram_addr_t   base;
		half_t       lo;
		half_t       hi;
		r    = next_random();
		addr = {7'd0, r[19:2], 2'b00};
		r    = next_random();
		lo   = r[15:0];
		hi   = r[31:16];
		base = (kind == DL_BIOS) ? BIOS_BASE : (kind == DL_EXE) ? EXE_BASE : '0;
		@(negedge clk_1x);
		while (ioctl_wait)
			@(negedge clk_1x);
		check_level("sys_reset", sys_reset, kind != DL_CDINFO);
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = lo;
		@(negedge clk_1x);
		ioctl_addr = addr | 27'd2;
		ioctl_dout = hi;
		exp_kind_q.push_back(kind);
		exp_addr_q.push_back(addr + base);
		exp_data_q.push_back({hi, lo});
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
		check_level("ioctl_wait", ioctl_wait, kind != DL_CDINFO);
		if (kind != DL_CDINFO) begin
			// Memory answers 1 to 8 cycles after the write
			r = next_random();
			repeat (1 + r[2:0]) begin
				@(negedge clk_1x);
				check_level("ioctl_wait", ioctl_wait, 1'b1);
			end
			ram_ack = 1'b1;
			@(negedge clk_1x);
			ram_ack = 1'b0;
			check_level("ioctl_wait", ioctl_wait, 1'b0);
		end
	endtask

	// Eight slices plus one stray odd offset
	task automatic send_code(input ram_addr_t base_addr);
		half_t       w [8];
		logic [31:0] r;
		cheat_code_t exp;
		for (int i = 0; i < 8; i++) begin
			r    = next_random();
			w[i] = r[15:0];
		end
		// Each field has its high half over its low half
		exp = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		for (int i = 0; i < 8; i++) begin
			if (i == 7) begin
				@(negedge clk_1x);
				ioctl_wr   = 1'b1;
				ioctl_addr = base_addr + 27'd1;
				ioctl_dout = ~w[0];
			end
			@(negedge clk_1x);
			ioctl_wr   = 1'b1;
			ioctl_addr = base_addr + ram_addr_t'(2 * i);
			ioctl_dout = w[i];
		end
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
		check_level("cheat_valid", cheat_valid, 1'b1);
		check_code(cheat_code, exp);
	endtask

	initial begin
		arst_n         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ram_ack        = 1'b0;
		reset_req      = 1'b0;
		osd_open       = 1'b0;
		pause_on_osd   = 1'b0;
		advance_req    = 1'b0;
		repeat (4) @(posedge clk_1x);
		@(negedge clk_1x);
		check_level("ioctl_wait", ioctl_wait, 1'b0);
		check_level("ram_wr", ram_wr, 1'b0);
		check_level("paused", paused, 1'b0);
		arst_n = 1'b1;

		set_download(1'b1, IDX_BIOS);
		repeat (N_BIOS) write_pair(DL_BIOS);
		set_download(1'b0, IDX_BIOS);
		set_download(1'b1, IDX_EXE);
		repeat (N_EXE) write_pair(DL_EXE);
		set_download(1'b0, IDX_EXE);
		// Start pulse one cycle after the kind leaves EXE
		check_level("load_exe", load_exe, 1'b1);
		check_level("sys_reset", sys_reset, 1'b0);
		set_download(1'b1, IDX_CDINFO);
		repeat (N_CDINFO) write_pair(DL_CDINFO);
		set_download(1'b0, IDX_CDINFO);

		set_download(1'b1, IDX_CODE);
		// Clear pulse one cycle after the kind becomes CODE
		check_level("cheat_clear", cheat_clear, 1'b1);
		for (int k = 0; k < N_CODES; k++)
			send_code(ram_addr_t'(16 * k));
		set_download(1'b0, IDX_CODE);

		reset_req = 1'b1;
		@(negedge clk_1x);
		check_level("sys_reset", sys_reset, 1'b1);
		reset_req = 1'b0;

		// Menu pause and one frame advance
		osd_open     = 1'b1;
		pause_on_osd = 1'b1;
		repeat (2) @(negedge clk_1x);
		check_level("paused", paused, 1'b1);
		advance_req = 1'b1;
		for (int n = 1; n <= HOLDOFF_CYCLES + 2; n++) begin
			@(negedge clk_1x);
			if (n == 3)
				advance_req = 1'b0;
			// Low for the whole hold-off from the second edge on
			check_level("paused", paused, !(n >= 2 && n <= HOLDOFF_CYCLES + 1));
		end
		osd_open = 1'b0;
		repeat (2) @(negedge clk_1x);
		check_level("paused", paused, 1'b0);

		if (exp_kind_q.size() != 0 || load_exe_seen != 1 || clear_seen != 1
				|| valid_seen != N_CODES) begin
			errors++;
			$display("%0d writes never seen, pulses load_exe %0d cheat_clear %0d cheat_valid %0d",
				exp_kind_q.size(), load_exe_seen, clear_seen, valid_seen);
		end
		asserts = u_psx_host_ctrl.u_psx_host_ctrl_assert.assert_fails;
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, asserts);
		if (errors == 0 && asserts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
